//--- verif/npu_axi_master_stimulus.txt
# kind unit addr(hex) size(beats) expected_bursts
# kind is R for a read or W for a write, unit is ignored for reads
W 0 10000000 50 4
W 1 20000000 37 3
R 0 00001000 40 3
R 0 00002000 16 1
W 0 10004000 16 1
R 0 00003000 5 1
R 0 00004000 33 3
W 1 20004000 3 1
R 0 00005000 1 1
R 0 00006000 64 4
W 0 10008000 17 2
W 1 20008000 31 2
R 0 00007000 20 2

//--- npu_axi_master.f
+incdir+common
common/npu_axi_master_pkg.sv
hdl/sync_fifo.sv
read_path/rd_burst_splitter.sv
write_path/wr_pu_tracker.sv
write_path/wr_data_mover.sv
hdl/npu_axi_master.sv
verif/npu_axi_master_asserts.sv
verif/npu_axi_master_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = npu_axi_master_tb
FILELIST = npu_axi_master.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run, check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verif/npu_axi_master_tb.sv
`timescale 1ns/1ps
`include "npu_axi_master_config.svh"

module npu_axi_master_tb;

  import npu_axi_master_pkg::*;

  localparam int TIMEOUT = 20000;

  logic clk = 1'b0;
  logic reset;
  logic rd_req;
  logic rd_ready;
  logic ar_valid;
  logic ar_ready;
  logic r_valid;
  logic r_ready;
  logic inbuf_full;
  logic inbuf_push;
  logic wr_req;
  logic wr_ready;
  logic wr_done;
  logic aw_valid;
  logic aw_ready;
  logic w_valid;
  logic w_ready;
  logic b_valid;
  logic b_ready;
  rd_req_t  rd_info;
  wr_req_t  wr_info;
  ax_req_t  ar;
  ax_req_t  aw;
  data_t    r_data;
  data_t    data_to_inbuf;
  w_beat_t  w;
  pu_mask_t outbuf_empty;
  pu_mask_t outbuf_pop;
  pu_data_t data_from_outbuf;

  logic [31:0] rng = 32'd84751;
  int mismatches = 0;
  int other_errs = 0;
  int done_cnt = 0;
  bit timed_out = 1'b0;
  int src_cnt [`NUM_PU];
  int exp_cnt [`NUM_PU];
  addr_t   r_pend [$];
  ax_req_t exp_ar [$];
  addr_t   exp_rbeat [$];
  ax_req_t exp_aw0 [$];
  ax_req_t exp_aw1 [$];
  burst_job_t aw_order [$];
  int w_idx = 0;
  int prev_u = -1;
  logic both_pending = 1'b0;

  // Request sizes and burst counts from the stimulus file
  int rd_sz [$];
  int rd_nb [$];
  int ar_beats = 0;
  int ar_bursts = 0;
  int wr_sz [`NUM_PU];
  int wr_nb [`NUM_PU];
  int aw_beats [`NUM_PU];
  int aw_bursts [`NUM_PU];

  npu_axi_master i_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_ax(input string name, input ax_req_t got, input ax_req_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %0t %s got addr=%h len=%0d exp addr=%h len=%0d",
               $time, name, got.addr, got.len, exp.addr, exp.len);
    end
  endtask

  task automatic check_beat(input string name, input w_beat_t got, input w_beat_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %0t %s got data=%h last=%b exp data=%h last=%b",
               $time, name, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      mismatches++;
      $display("MISMATCH %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    other_errs++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  //////////////////////////////
  // Random ready and empty
  //////////////////////////////
  always @(posedge clk)
  begin
    rng = xorshift(rng);
    ar_ready     <= rng[0] | rng[1];
    aw_ready     <= rng[2] | rng[3];
    w_ready      <= rng[4] | rng[5];
    inbuf_full   <= rng[6] & rng[7];
    outbuf_empty <= {rng[8] & rng[9], rng[10] & rng[11]};
  end

  // AXI slave read model returning each beat's address as data
  always @(posedge clk)
  begin
    if (r_valid && r_ready)
      void'(r_pend.pop_front());
    if (ar_valid && ar_ready)
    begin
      for (int i = 0; i <= int'(ar.len); i++)
        r_pend.push_back(ar.addr + addr_t'(i * 8));
    end
    r_valid <= (r_pend.size() > 0);
    r_data  <= (r_pend.size() > 0) ? data_t'(r_pend[0]) : '0;
  end

  // Output buffer models with the unit index high and a running count low
  always @(posedge clk)
  begin
    for (int u = 0; u < `NUM_PU; u++)
    begin
      if (!reset && outbuf_pop[u])
      begin
        data_from_outbuf[u] <= {32'(u), 32'(src_cnt[u])};
        src_cnt[u]++;
      end
    end
  end

  //////////////////////////////
  // Monitors
  //////////////////////////////
  always @(posedge clk)
  begin
    int u;
    w_beat_t eb;
    ax_req_t ea;
    if (!reset)
    begin
      if (inbuf_push && inbuf_full)
      begin
        other_errs++;
        $display("Beat pushed into a full input buffer at %0t", $time);
      end
      if (inbuf_push)
      begin
        if (exp_rbeat.size() == 0)
        begin
          other_errs++;
          $display("Unexpected input buffer push at %0t", $time);
        end
        else
          check_data("data_to_inbuf", data_to_inbuf, data_t'(exp_rbeat.pop_front()));
      end
      if (ar_valid && ar_ready)
      begin
        if (exp_ar.size() == 0)
        begin
          other_errs++;
          $display("Unexpected AR burst at %0t", $time);
        end
        else
          check_ax("ar", ar, exp_ar.pop_front());
        // Bursts of one request end when their beats cover its size
        ar_bursts++;
        ar_beats += int'(ar.len) + 1;
        if (rd_sz.size() > 0 && ar_beats >= rd_sz[0])
        begin
          check_count("ar_bursts", ar_bursts, rd_nb.pop_front());
          void'(rd_sz.pop_front());
          ar_bursts = 0;
          ar_beats  = 0;
        end
      end
      if (aw_valid && aw_ready)
      begin
        if (exp_aw0.size() == 0 && exp_aw1.size() == 0)
        begin
          other_errs++;
          $display("Unexpected AW burst at %0t", $time);
        end
        else
        begin
          // Distinct address ranges tell the units apart
          if (exp_aw1.size() == 0)
            u = 0;
          else if (exp_aw0.size() == 0)
            u = 1;
          else
            u = (aw.addr == exp_aw0[0].addr) ? 0 : 1;
          if (both_pending && u == prev_u)
          begin
            other_errs++;
            $display("AW bursts did not alternate between units at %0t", $time);
          end
          if (u == 0)
            ea = exp_aw0.pop_front();
          else
            ea = exp_aw1.pop_front();
          check_ax("aw", aw, ea);
          aw_order.push_back('{pu_id: pu_id_t'(u), len: ea.len});
          aw_bursts[u]++;
          aw_beats[u] += int'(aw.len) + 1;
          if (aw_beats[u] >= wr_sz[u])
          begin
            check_count("aw_bursts", aw_bursts[u], wr_nb[u]);
            aw_bursts[u] = 0;
            aw_beats[u]  = 0;
          end
          prev_u = u;
          both_pending = (exp_aw0.size() > 0) && (exp_aw1.size() > 0);
        end
      end
      if (w_valid && w_ready)
      begin
        if (aw_order.size() == 0)
        begin
          other_errs++;
          $display("W beat with no AW burst ahead at %0t", $time);
        end
        else
        begin
          u = int'(aw_order[0].pu_id);
          eb.data = {32'(u), 32'(exp_cnt[u])};
          eb.last = (w_idx == int'(aw_order[0].len));
          check_beat("w", w, eb);
          exp_cnt[u]++;
          if (eb.last)
          begin
            w_idx = 0;
            void'(aw_order.pop_front());
          end
          else
            w_idx++;
        end
      end
      if (wr_done)
        done_cnt++;
    end
  end

  //////////////////////////////
  // Requests
  //////////////////////////////
  // Queues the expected bursts and beats of one request
  function automatic void split(input addr_t a, input tx_size_t s, input int unit,
                                input bit rd);
    int n;
    int beats;
    tx_size_t left;
    ax_req_t e;
    n = 0;
    left = s;
    while (left != 0)
    begin
      beats = (left > 16) ? 16 : int'(left);
      e.addr = a + addr_t'(n * 128);
      e.len  = burst_len_t'(beats - 1);
      if (rd)
      begin
        exp_ar.push_back(e);
        for (int i = 0; i < beats; i++)
          exp_rbeat.push_back(e.addr + addr_t'(i * 8));
      end
      else if (unit == 0)
        exp_aw0.push_back(e);
      else
        exp_aw1.push_back(e);
      left = left - tx_size_t'(beats);
      n++;
    end
  endfunction

  task automatic send_req(input bit rd, input int unit, input addr_t a, input tx_size_t s,
                          input int nb);
    int t;
    @(posedge clk);
    if (rd)
      rd_info <= '{addr: a, size: s};
    else
      wr_info <= '{pu_id: pu_id_t'(unit), addr: a, size: s};
    @(posedge clk);
    t = 0;
    while ((rd ? !rd_ready : !wr_ready) && !timed_out)
    begin
      t++;
      if (t > TIMEOUT)
        report_timeout(rd ? "rd_ready" : "wr_ready");
      else
        @(posedge clk);
    end
    if (!timed_out)
    begin
      if (rd)
        rd_req <= 1'b1;
      else
        wr_req <= 1'b1;
      @(posedge clk);
      rd_req <= 1'b0;
      wr_req <= 1'b0;
      split(a, s, unit, rd);
      if (rd)
      begin
        rd_sz.push_back(int'(s));
        rd_nb.push_back(nb);
      end
      else
      begin
        wr_sz[unit] = int'(s);
        wr_nb[unit] = nb;
        done_cnt = 0;
      end
    end
  endtask

  initial
  begin
    int fd;
    int code;
    int kind;
    int unit;
    int size;
    int nb;
    int t;
    logic [31:0] addr;
    string line;
    reset = 1'b1;
    rd_req = 1'b0;
    rd_info = '0;
    wr_req = 1'b0;
    wr_info = '0;
    ar_ready = 1'b0;
    aw_ready = 1'b0;
    w_ready = 1'b0;
    r_valid = 1'b0;
    r_data = '0;
    inbuf_full = 1'b0;
    b_valid = 1'b0;
    outbuf_empty = '1;
    data_from_outbuf = '0;
    for (int u = 0; u < `NUM_PU; u++)
    begin
      src_cnt[u] = 0;
      exp_cnt[u] = 0;
      wr_sz[u] = 0;
      wr_nb[u] = 0;
      aw_beats[u] = 0;
      aw_bursts[u] = 0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    fd = $fopen("verif/npu_axi_master_stimulus.txt", "r");
    if (fd == 0)
    begin
      other_errs++;
      $display("Cannot open the stimulus file");
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 3 || line[0] == "#")
          continue;
        code = $sscanf(line, "%c %d %h %d %d", kind, unit, addr, size, nb);
        if (code != 5)
          continue;
        send_req(kind == "R", unit, addr_t'(addr), tx_size_t'(size), nb);
      end
      $fclose(fd);
    end

    // Drain of both paths
    t = 0;
    while (exp_ar.size() + exp_rbeat.size() + exp_aw0.size() + exp_aw1.size() +
           aw_order.size() != 0 && !timed_out)
    begin
      t++;
      if (t > TIMEOUT)
        report_timeout("all bursts and beats");
      else
        @(posedge clk);
    end
    t = 0;
    while (done_cnt == 0 && !timed_out)
    begin
      t++;
      if (t > TIMEOUT)
        report_timeout("wr_done");
      else
        @(posedge clk);
    end
    if (!timed_out)
    begin
      repeat (20) @(posedge clk);
      if (done_cnt != 1)
      begin
        other_errs++;
        $display("wr_done pulsed %0d times after the last write", done_cnt);
      end
      for (int u = 0; u < `NUM_PU; u++)
      begin
        wr_info <= '{pu_id: pu_id_t'(u), addr: '0, size: '0};
        @(posedge clk);
        @(posedge clk);
        if (!wr_ready)
        begin
          other_errs++;
          $display("wr_ready low for idle unit %0d", u);
        end
      end
      if (!b_ready)
      begin
        other_errs++;
        $display("b_ready low after reset");
      end
    end
    $display("Errors: mismatches=%0d other=%0d", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- verif/npu_axi_master_asserts.sv
`timescale 1ns/1ps

module npu_axi_master_asserts
(
  input logic                         clk,
  input logic                         reset,
  input npu_axi_master_pkg::ax_req_t  ar,
  input logic                         ar_valid,
  input logic                         ar_ready,
  input npu_axi_master_pkg::ax_req_t  aw,
  input logic                         aw_valid,
  input logic                         aw_ready,
  input npu_axi_master_pkg::w_beat_t  w,
  input logic                         w_valid,
  input logic                         w_ready,
  input npu_axi_master_pkg::pu_mask_t outbuf_empty,
  input npu_axi_master_pkg::pu_mask_t outbuf_pop
);

  logic aw_seen;

  // Set by the first AW handshake
  always_ff @(posedge clk)
  begin
    if (reset)
      aw_seen <= 1'b0;
    else if (aw_valid && aw_ready)
      aw_seen <= 1'b1;
  end

  //////////////////////////////
  // Channel stability
  //////////////////////////////
  ar_stable: assert property (@(posedge clk) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("AR payload or valid changed before ready");

  aw_stable: assert property (@(posedge clk) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("AW payload or valid changed before ready");

  w_stable: assert property (@(posedge clk) disable iff (reset)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("W payload or valid changed before ready");

  // Output buffers
  pop_not_empty: assert property (@(posedge clk) disable iff (reset)
    (outbuf_pop & outbuf_empty) == '0)
    else $error("Output buffer popped while empty");

  w_after_aw: assert property (@(posedge clk) disable iff (reset)
    w_valid |-> aw_seen)
    else $error("W valid before any AW handshake");

endmodule

bind npu_axi_master npu_axi_master_asserts i_asserts (.*);

//--- hdl/npu_axi_master.sv
`timescale 1ns/1ps

module npu_axi_master
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         rd_req,
  input  npu_axi_master_pkg::rd_req_t  rd_info,
  output logic                         rd_ready,
  output npu_axi_master_pkg::ax_req_t  ar,
  output logic                         ar_valid,
  input  logic                         ar_ready,
  input  npu_axi_master_pkg::data_t    r_data,
  input  logic                         r_valid,
  output logic                         r_ready,
  input  logic                         inbuf_full,
  output logic                         inbuf_push,
  output npu_axi_master_pkg::data_t    data_to_inbuf,
  input  logic                         wr_req,
  input  npu_axi_master_pkg::wr_req_t  wr_info,
  output logic                         wr_ready,
  output logic                         wr_done,
  output npu_axi_master_pkg::ax_req_t  aw,
  output logic                         aw_valid,
  input  logic                         aw_ready,
  output npu_axi_master_pkg::w_beat_t  w,
  output logic                         w_valid,
  input  logic                         w_ready,
  input  logic                         b_valid,
  output logic                         b_ready,
  input  npu_axi_master_pkg::pu_mask_t outbuf_empty,
  output npu_axi_master_pkg::pu_mask_t outbuf_pop,
  input  npu_axi_master_pkg::pu_data_t data_from_outbuf
);

  import npu_axi_master_pkg::*;

  burst_job_t job;
  logic       job_push;
  logic       job_full;
  logic       mover_idle;

  //////////////////////////////
  // Read path
  //////////////////////////////
  rd_burst_splitter i_rd_splitter (
    .clk           (clk),
    .reset         (reset),
    .rd_req        (rd_req),
    .rd_info       (rd_info),
    .rd_ready      (rd_ready),
    .ar            (ar),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r_data        (r_data),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .inbuf_full    (inbuf_full),
    .inbuf_push    (inbuf_push),
    .data_to_inbuf (data_to_inbuf)
  );

  //////////////////////////////
  // Write path
  //////////////////////////
  wr_pu_tracker i_wr_tracker (
    .clk        (clk),
    .reset      (reset),
    .wr_req     (wr_req),
    .wr_info    (wr_info),
    .wr_ready   (wr_ready),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .job        (job),
    .job_push   (job_push),
    .job_full   (job_full),
    .mover_idle (mover_idle),
    .wr_done    (wr_done)
  );

  wr_data_mover i_wr_mover (
    .clk              (clk),
    .reset            (reset),
    .job              (job),
    .job_push         (job_push),
    .job_full         (job_full),
    .outbuf_empty     (outbuf_empty),
    .outbuf_pop       (outbuf_pop),
    .data_from_outbuf (data_from_outbuf),
    .w                (w),
    .w_valid          (w_valid),
    .w_ready          (w_ready),
    .idle             (mover_idle)
  );

  // Write responses are always accepted
  always_ff @(posedge clk)
  begin
    if (reset)
      b_ready <= 1'b0;
    else
      b_ready <= 1'b1;
  end

endmodule

//--- write_path/wr_data_mover.sv
`timescale 1ns/1ps
`include "npu_axi_master_config.svh"

module wr_data_mover
(
  input  logic                           clk,
  input  logic                           reset,
  input  npu_axi_master_pkg::burst_job_t job,
  input  logic                           job_push,
  output logic                           job_full,
  input  npu_axi_master_pkg::pu_mask_t   outbuf_empty,
  output npu_axi_master_pkg::pu_mask_t   outbuf_pop,
  input  npu_axi_master_pkg::pu_data_t   data_from_outbuf,
  output npu_axi_master_pkg::w_beat_t    w,
  output logic                           w_valid,
  input  logic                           w_ready,
  output logic                           idle
);

  import npu_axi_master_pkg::*;

  localparam logic [`WBUF_DEPTH_LOG:0] ALMOST_FULL = `WBUF_ALMOST_FULL;

  burst_job_t                cur_job;
  logic                      jq_empty;
  logic                      jq_pop;
  burst_len_t                beat_cnt;
  logic                      beat_last;
  logic                      rd_en;
  logic                      pop_d;
  pu_id_t                    pu_d;
  logic                      last_d;
  w_beat_t                   wbuf_in;
  logic                      wbuf_empty;
  logic [`WBUF_DEPTH_LOG:0]  wbuf_count;

  //////////////////////////////
  // Job queue, one entry per AW burst
  //////////////////////////////
  sync_fifo #(
    .WIDTH     ($bits(burst_job_t)),
    .DEPTH_LOG (`JOB_Q_DEPTH_LOG)
  ) i_job_q (
    .clk      (clk),
    .reset    (reset),
    .push     (job_push),
    .data_in  (job),
    .pop      (jq_pop),
    .data_out (cur_job),
    .full     (job_full),
    .empty    (jq_empty),
    .count    ()
  );

  //////////////////////////////
  // Output buffer reader
  //////////////////////////////
  // Stall on a nearly full write buffer or an empty source
  assign rd_en = !jq_empty && (wbuf_count < ALMOST_FULL) && !outbuf_empty[cur_job.pu_id];

  assign beat_last = (beat_cnt == cur_job.len);
  assign jq_pop    = rd_en && beat_last;

  always_comb
  begin
    outbuf_pop = '0;
    if (rd_en)
      outbuf_pop[cur_job.pu_id] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      beat_cnt <= '0;
    else if (rd_en)
      beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
  end

  // Word returns one cycle after its pop
  always_ff @(posedge clk)
  begin
    if (reset)
      pop_d <= 1'b0;
    else
      pop_d <= rd_en;
  end

  always_ff @(posedge clk)
  begin
    pu_d   <= cur_job.pu_id;
    last_d <= beat_last;
  end

  //////////////////////////////
  // Write buffer feeding W
  //////////////////////////////
  assign wbuf_in = '{data: data_from_outbuf[pu_d], last: last_d};

  sync_fifo #(
    .WIDTH     ($bits(w_beat_t)),
    .DEPTH_LOG (`WBUF_DEPTH_LOG)
  ) i_wbuf (
    .clk      (clk),
    .reset    (reset),
    .push     (pop_d),
    .data_in  (wbuf_in),
    .pop      (w_valid && w_ready),
    .data_out (w),
    .full     (),
    .empty    (wbuf_empty),
    .count    (wbuf_count)
  );

  assign w_valid = !wbuf_empty;

  // Nothing queued, buffered or in flight
  assign idle = jq_empty && wbuf_empty && !pop_d;

endmodule

//--- write_path/wr_pu_tracker.sv
`timescale 1ns/1ps
`include "npu_axi_master_config.svh"

module wr_pu_tracker
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           wr_req,
  input  npu_axi_master_pkg::wr_req_t    wr_info,
  output logic                           wr_ready,
  output npu_axi_master_pkg::ax_req_t    aw,
  output logic                           aw_valid,
  input  logic                           aw_ready,
  output npu_axi_master_pkg::burst_job_t job,
  output logic                           job_push,
  input  logic                           job_full,
  input  logic                           mover_idle,
  output logic                           wr_done
);

  import npu_axi_master_pkg::*;

  addr_t    pu_addr [`NUM_PU];
  tx_size_t pu_left [`NUM_PU];
  pu_mask_t busy;
  pu_id_t   rr_ptr;
  pu_id_t   sel;
  logic     sel_found;
  pu_id_t   aw_pu;
  logic     wr_accept;
  logic     issue;
  logic     aw_done;
  logic     all_idle;
  logic     all_idle_d;

  always_comb
  begin
    for (int i = 0; i < `NUM_PU; i++)
      busy[i] = (pu_left[i] != '0);
  end

  assign wr_ready  = !busy[wr_info.pu_id];
  assign wr_accept = wr_req && wr_ready;
  assign aw_done   = aw_valid && aw_ready;
  assign issue     = !aw_valid && !job_full && sel_found;

  //////////////////////////////
  // Per-unit address and count
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `NUM_PU; i++)
        pu_left[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < `NUM_PU; i++)
      begin
        if (wr_accept && wr_info.pu_id == pu_id_t'(i))
          pu_left[i] <= wr_info.size;
        else if (aw_done && aw_pu == pu_id_t'(i))
          pu_left[i] <= pu_left[i] - (tx_size_t'(aw.len) + tx_size_t'(1));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `NUM_PU; i++)
    begin
      if (wr_accept && wr_info.pu_id == pu_id_t'(i))
        pu_addr[i] <= wr_info.addr;
      else if (aw_done && aw_pu == pu_id_t'(i))
        pu_addr[i] <= pu_addr[i] + addr_t'(`BURST_BYTES);
    end
  end

  //////////////////////////////
  // Round-robin AW issue
  //////////////////////////////
  // First busy unit at or after the pointer
  always_comb
  begin
    int unsigned idx;
    sel       = rr_ptr;
    sel_found = 1'b0;
    for (int k = 0; k < `NUM_PU; k++)
    begin
      idx = (int'(rr_ptr) + k) % `NUM_PU;
      if (!sel_found && busy[idx])
      begin
        sel       = pu_id_t'(idx);
        sel_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      aw_valid <= 1'b0;
      rr_ptr   <= '0;
    end
    else if (issue)
    begin
      aw_valid <= 1'b1;
      rr_ptr   <= pu_id_t'((int'(sel) + 1) % `NUM_PU);
    end
    else if (aw_done)
      aw_valid <= 1'b0;
  end

  // Held steady while aw_valid waits for ready
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      aw.addr <= pu_addr[sel];
      aw.len  <= burst_len(pu_left[sel]);
      aw_pu   <= sel;
    end
  end

  // Burst handed to the mover as AW completes
  assign job_push = aw_done;
  assign job      = '{pu_id: aw_pu, len: aw.len};

  //////////////////////////////
  // Drain detect
  //////////////////////////////
  assign all_idle = !(|busy) && mover_idle;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // Starts high, so leaving reset gives no pulse
      all_idle_d <= 1'b1;
      wr_done    <= 1'b0;
    end
    else
    begin
      all_idle_d <= all_idle;
      wr_done    <= all_idle && !all_idle_d;
    end
  end

endmodule

//--- read_path/rd_burst_splitter.sv
`timescale 1ns/1ps
`include "npu_axi_master_config.svh"

module rd_burst_splitter
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        rd_req,
  input  npu_axi_master_pkg::rd_req_t rd_info,
  output logic                        rd_ready,
  output npu_axi_master_pkg::ax_req_t ar,
  output logic                        ar_valid,
  input  logic                        ar_ready,
  input  npu_axi_master_pkg::data_t   r_data,
  input  logic                        r_valid,
  output logic                        r_ready,
  input  logic                        inbuf_full,
  output logic                        inbuf_push,
  output npu_axi_master_pkg::data_t   data_to_inbuf
);

  import npu_axi_master_pkg::*;

  rd_req_t    q_head;
  logic       q_full;
  logic       q_empty;
  logic       q_pop;
  tx_size_t   beats_left;
  addr_t      burst_addr;
  burst_len_t cur_len;
  logic       ar_done;

  //////////////////////////////
  // Request queue
  //////////////////////////////
  assign rd_ready = !q_full;

  sync_fifo #(
    .WIDTH     ($bits(rd_req_t)),
    .DEPTH_LOG (`RD_Q_DEPTH_LOG)
  ) i_req_q (
    .clk      (clk),
    .reset    (reset),
    .push     (rd_req && rd_ready),
    .data_in  (rd_info),
    .pop      (q_pop),
    .data_out (q_head),
    .full     (q_full),
    .empty    (q_empty),
    .count    ()
  );

  // Next request only once every burst of the current one is out
  assign q_pop = (beats_left == '0) && !q_empty;

  //////////////////////////////
  // AR bursts
  //////////////////////////////
  // beats_left holds the beats not yet accepted on AR, so it alone marks a pending burst
  assign cur_len  = burst_len(beats_left);
  assign ar_valid = (beats_left != '0);
  assign ar       = '{addr: burst_addr, len: cur_len};
  assign ar_done  = ar_valid && ar_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
      beats_left <= '0;
    else if (q_pop)
      beats_left <= q_head.size;
    else if (ar_done)
      beats_left <= beats_left - (tx_size_t'(cur_len) + tx_size_t'(1));
  end

  // Running burst address
  always_ff @(posedge clk)
  begin
    if (q_pop)
      burst_addr <= q_head.addr;
    else if (ar_done)
      burst_addr <= burst_addr + addr_t'(`BURST_BYTES);
  end

  //////////////////////////////
  // R beats into the input buffer
  //////////////////////////////
  assign r_ready       = !inbuf_full;
  assign inbuf_push    = r_valid && r_ready;
  assign data_to_inbuf = r_data;

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
#(
  parameter int WIDTH     = 8,
  parameter int DEPTH_LOG = 2
)
(
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  logic [WIDTH-1:0]   data_in,
  input  logic               pop,
  output logic [WIDTH-1:0]   data_out,
  output logic               full,
  output logic               empty,
  output logic [DEPTH_LOG:0] count
);

  logic [WIDTH-1:0]   mem [2**DEPTH_LOG];
  logic [DEPTH_LOG:0] wr_ptr;
  logic [DEPTH_LOG:0] rd_ptr;
  logic               do_push;
  logic               do_pop;

  // Extra pointer bit tells full from empty
  assign count = wr_ptr - rd_ptr;
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[DEPTH_LOG] != rd_ptr[DEPTH_LOG]) &&
                 (wr_ptr[DEPTH_LOG-1:0] == rd_ptr[DEPTH_LOG-1:0]);

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head entry shows on the output before any pop
  assign data_out = mem[rd_ptr[DEPTH_LOG-1:0]];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr[DEPTH_LOG-1:0]] <= data_in;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- common/npu_axi_master_pkg.sv
`include "npu_axi_master_config.svh"

package npu_axi_master_pkg;

  //////////////////////////////
  // Scalar types
  //////////////////////////////
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;
  typedef logic [`TX_SIZE_W-1:0]  tx_size_t;
  typedef logic [`PU_ID_W-1:0]    pu_id_t;
  typedef logic [3:0]             burst_len_t;
  typedef logic [`NUM_PU-1:0]     pu_mask_t;

  // One word per output buffer with unit 0 in the low slot
  typedef data_t [`NUM_PU-1:0] pu_data_t;

  //////////////////////////////
  // Request and channel structs
  //////////////////////////////
  typedef struct packed {
    addr_t    addr;
    tx_size_t size;
  } rd_req_t;

  typedef struct packed {
    pu_id_t   pu_id;
    addr_t    addr;
    tx_size_t size;
  } wr_req_t;

  // AR or AW command with len as beats minus one
  typedef struct packed {
    addr_t      addr;
    burst_len_t len;
  } ax_req_t;

  typedef struct packed {
    pu_id_t     pu_id;
    burst_len_t len;
  } burst_job_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_beat_t;

  // Length field of the next burst for a nonzero beat count
  function automatic burst_len_t burst_len(input tx_size_t beats);
    if (beats >= tx_size_t'(`MAX_BURST))
      return burst_len_t'(`MAX_BURST - 1);
    return burst_len_t'(beats - tx_size_t'(1));
  endfunction

endpackage

//--- common/npu_axi_master_config.svh
`ifndef NPU_AXI_MASTER_CONFIG_SVH
`define NPU_AXI_MASTER_CONFIG_SVH

//////////////////////////////
// Bus widths
//////////////////////////////
`define AXI_ADDR_W 32
`define AXI_DATA_W 64

// Request size counted in beats
`define TX_SIZE_W 10

//////////////////////////////
// Processing units
//////////////////////////////
`define NUM_PU 2
`define PU_ID_W 1

//////////////////////////////
// Bursts and queues
//////////////////////////////
`define MAX_BURST 16
// 16 beats of 8 bytes
`define BURST_BYTES 128

`define RD_Q_DEPTH_LOG 2
`define JOB_Q_DEPTH_LOG 4
`define WBUF_DEPTH_LOG 5
// Leaves room for beats already in flight
`define WBUF_ALMOST_FULL 24

`endif
